//--- common/hbus_macros.svh
`ifndef HBUS_MACROS_SVH
`define HBUS_MACROS_SVH

// byte address on both buses
`define HBUS_ADDR_WIDTH 32

// wishbone data bus
`define WB_DATA_WIDTH 32

// controller request port, one wishbone word per request
`define HBUS_DATA_WIDTH 32

// cdc fifo holds 1 << this many entries
`define HBUS_FIFO_DEPTH_LOG2 2

`endif

//--- common/hbus_pkg.sv
`default_nettype none

`include "hbus_macros.svh"

package hbus_pkg;

  // set bit = lane masked, inverse of wb_sel
  typedef logic [`HBUS_DATA_WIDTH/8-1:0] hbus_mask_t;

  // one request toward the controller
  typedef struct packed {
    logic                        we;   // 1 = write
    logic [`HBUS_ADDR_WIDTH-1:0] adr;  // word aligned
    logic [`HBUS_DATA_WIDTH-1:0] dat;
    hbus_mask_t                  mask;
  } hbus_req_t;

  // completion coming back
  typedef struct packed {
    logic                        we;   // write completion, no data
    logic [`HBUS_DATA_WIDTH-1:0] dat;
  } hbus_rsp_t;

endpackage

`default_nettype wire

//--- common/hbus_req_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "hbus_macros.svh"

interface hbus_req_if;
  import hbus_pkg::*;

  logic                        rrq;      // pulses
  logic                        wrq;
  logic [`HBUS_ADDR_WIDTH-1:0] adr;      // held while pending
  logic [`WB_DATA_WIDTH-1:0]   tx_dat;
  hbus_mask_t                  tx_mask;
  logic [`WB_DATA_WIDTH-1:0]   rx_dat;   // valid with rx_valid
  logic                        tx_ready; // write done
  logic                        rx_valid; // read done

  // wishbone side
  modport slave (
    output rrq, wrq, adr, tx_dat, tx_mask,
    input  rx_dat, tx_ready, rx_valid
  );

  // cdc side
  modport fifo (
    input  rrq, wrq, adr, tx_dat, tx_mask,
    output rx_dat, tx_ready, rx_valid
  );

endinterface

`default_nettype wire

//--- hw/hyperbus_bridge_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "hbus_macros.svh"

module hyperbus_bridge_top (
  input  wire                         wb_clk,
  input  wire                         wb_rst,
  input  wire [`HBUS_ADDR_WIDTH-1:0]  wb_adr_i,
  input  wire [`WB_DATA_WIDTH-1:0]    wb_dat_i,
  input  wire                         wb_we_i,
  input  wire                         wb_cyc_i,
  input  wire                         wb_stb_i,
  input  wire [`WB_DATA_WIDTH/8-1:0]  wb_sel_i,
  output logic [`WB_DATA_WIDTH-1:0]   wb_dat_o,
  output logic                        wb_ack_o,
  input  wire                         hbus_clk,
  input  wire                         hbus_rst,
  output logic [`HBUS_ADDR_WIDTH-1:0] hbus_adr_o,
  output logic [`HBUS_DATA_WIDTH-1:0] hbus_dat_o,
  output hbus_pkg::hbus_mask_t        hbus_mask_o,
  output logic                        hbus_rrq,
  output logic                        hbus_wrq,
  input  wire [`HBUS_DATA_WIDTH-1:0]  hbus_dat_i,
  input  wire                         hbus_ready,
  input  wire                         hbus_valid,
  input  wire                         hbus_busy
);

  hbus_req_if req_if ();

  hyperbus_wishbone u_wb (
    .wb_clk   (wb_clk),
    .wb_rst   (wb_rst),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_we_i  (wb_we_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_sel_i (wb_sel_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .req      (req_if.slave)
  );

  // crosses into hbus_clk and drives the controller port
  hyperbus_fifo u_fifo (
    .hbus_clk    (hbus_clk),
    .hbus_rst    (hbus_rst),
    .wb_clk      (wb_clk),
    .wb_rst      (wb_rst),
    .req         (req_if.fifo),
    .hbus_adr_o  (hbus_adr_o),
    .hbus_dat_o  (hbus_dat_o),
    .hbus_mask_o (hbus_mask_o),
    .hbus_rrq    (hbus_rrq),
    .hbus_wrq    (hbus_wrq),
    .hbus_dat_i  (hbus_dat_i),
    .hbus_ready  (hbus_ready),
    .hbus_valid  (hbus_valid),
    .hbus_busy   (hbus_busy)
  );

endmodule

`default_nettype wire

//--- hw/hyperbus_wishbone.sv
`timescale 1ns/1ps
`default_nettype none

`include "hbus_macros.svh"

module hyperbus_wishbone (
  input  wire                        wb_clk,
  input  wire                        wb_rst,
  input  wire [`HBUS_ADDR_WIDTH-1:0] wb_adr_i,
  input  wire [`WB_DATA_WIDTH-1:0]   wb_dat_i,
  input  wire                        wb_we_i,
  input  wire                        wb_cyc_i,
  input  wire                        wb_stb_i,
  input  wire [`WB_DATA_WIDTH/8-1:0] wb_sel_i,
  output logic [`WB_DATA_WIDTH-1:0]  wb_dat_o,
  output logic                       wb_ack_o,
  hbus_req_if.slave                  req
);

  localparam logic [2:0] st_idle  = 3'b001;
  localparam logic [2:0] st_write = 3'b010;
  localparam logic [2:0] st_read  = 3'b100;

  logic [2:0] state;
  logic       strobe;

  // no new cycle in the ack cycle itself
  assign strobe = wb_cyc_i & wb_stb_i & ~wb_ack_o;

  always_ff @(posedge wb_clk) begin
    if (wb_rst) begin
      state    <= st_idle;
      req.rrq  <= 1'b0;
      req.wrq  <= 1'b0;
      wb_ack_o <= 1'b0;
    end else begin
      req.rrq  <= 1'b0;
      req.wrq  <= 1'b0;
      wb_ack_o <= 1'b0;

      case (state)
        st_idle: begin
          if (strobe && wb_we_i) begin
            req.wrq <= 1'b1;
            state   <= st_write;
          end else if (strobe) begin
            req.rrq <= 1'b1;
            state   <= st_read;
          end
        end

        st_write: begin
          if (req.tx_ready) begin
            wb_ack_o <= 1'b1;
            state    <= st_idle;
          end
        end

        st_read: begin
          if (req.rx_valid) begin
            wb_ack_o <= 1'b1;
            state    <= st_idle;
          end
        end

        default: state <= st_idle;
      endcase
    end
  end

  // request payload, held until the next strobe
  always_ff @(posedge wb_clk) begin
    if (state == st_idle && strobe) begin
      req.adr     <= {wb_adr_i[`HBUS_ADDR_WIDTH-1:2], 2'b00}; // word aligned
      req.tx_dat  <= wb_dat_i;
      req.tx_mask <= ~wb_sel_i;
    end
  end

  always_ff @(posedge wb_clk) begin
    if (req.rx_valid) begin
      wb_dat_o <= req.rx_dat; // lines up with ack
    end
  end

  a_one_request: assert property (
    @(posedge wb_clk) disable iff (wb_rst) !(req.rrq && req.wrq)
  );

  // ack is a single-cycle pulse
  a_ack_pulse: assert property (
    @(posedge wb_clk) disable iff (wb_rst) wb_ack_o |=> !wb_ack_o
  );

endmodule

`default_nettype wire

//--- hyperbus_fifo/hbus_cdc_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "hbus_macros.svh"

module hbus_cdc_fifo #(
  parameter type payload_t = logic [7:0]
) (
  input  wire      wr_clk_i,
  input  wire      wr_rst_i,
  input  wire      wr_en_i,
  input  payload_t wr_data_i,
  output logic     full_o,
  input  wire      rd_clk_i,
  input  wire      rd_rst_i,
  input  wire      rd_en_i,
  output payload_t rd_data_o,
  output logic     empty_o
);

  localparam int aw    = `HBUS_FIFO_DEPTH_LOG2;
  localparam int depth = 1 << aw;

  // gray full compare flips the two top bits
  localparam logic [aw:0] full_xor = 3 << (aw - 1);

  payload_t mem [depth];

  logic [aw:0] wr_bin, wr_bin_nxt, wr_gray;
  logic [aw:0] rd_bin, rd_bin_nxt, rd_gray;
  logic [aw:0] rq1, rq2; // read pointer, wr domain
  logic [aw:0] wq1, wq2; // write pointer, rd domain
  logic        wr_push;
  logic        rd_pop;

  assign wr_push    = wr_en_i & ~full_o;
  assign rd_pop     = rd_en_i & ~empty_o;
  assign wr_bin_nxt = wr_bin + 1'b1;
  assign rd_bin_nxt = rd_bin + 1'b1;

  // write domain
  always_ff @(posedge wr_clk_i) begin
    if (wr_rst_i) begin
      wr_bin  <= '0;
      wr_gray <= '0;
      rq1     <= '0;
      rq2     <= '0;
    end else begin
      rq1 <= rd_gray;
      rq2 <= rq1;
      if (wr_push) begin
        wr_bin  <= wr_bin_nxt;
        wr_gray <= wr_bin_nxt ^ (wr_bin_nxt >> 1);
      end
    end
  end

  always_ff @(posedge wr_clk_i) begin
    if (wr_push) begin
      mem[wr_bin[aw-1:0]] <= wr_data_i;
    end
  end

  assign full_o = (wr_gray == (rq2 ^ full_xor));

  // read domain
  always_ff @(posedge rd_clk_i) begin
    if (rd_rst_i) begin
      rd_bin  <= '0;
      rd_gray <= '0;
      wq1     <= '0;
      wq2     <= '0;
    end else begin
      wq1 <= wr_gray;
      wq2 <= wq1;
      if (rd_pop) begin
        rd_bin  <= rd_bin_nxt;
        rd_gray <= rd_bin_nxt ^ (rd_bin_nxt >> 1);
      end
    end
  end

  assign empty_o   = (rd_gray == wq2);
  assign rd_data_o = mem[rd_bin[aw-1:0]]; // show-ahead

  a_no_overflow: assert property (
    @(posedge wr_clk_i) disable iff (wr_rst_i) wr_en_i |-> !full_o
  );

  a_no_underflow: assert property (
    @(posedge rd_clk_i) disable iff (rd_rst_i) rd_en_i |-> !empty_o
  );

endmodule

`default_nettype wire

//--- hyperbus_fifo/hyperbus_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "hbus_macros.svh"

module hyperbus_fifo (
  input  wire                         hbus_clk,
  input  wire                         hbus_rst,
  input  wire                         wb_clk,
  input  wire                         wb_rst,
  hbus_req_if.fifo                    req,
  output logic [`HBUS_ADDR_WIDTH-1:0] hbus_adr_o,
  output logic [`HBUS_DATA_WIDTH-1:0] hbus_dat_o,
  output hbus_pkg::hbus_mask_t        hbus_mask_o,
  output logic                        hbus_rrq,
  output logic                        hbus_wrq,
  input  wire [`HBUS_DATA_WIDTH-1:0]  hbus_dat_i,
  input  wire                         hbus_ready,
  input  wire                         hbus_valid,
  input  wire                         hbus_busy
);
  import hbus_pkg::*;

  localparam logic [1:0] st_idle  = 2'd0;
  localparam logic [1:0] st_issue = 2'd1;
  localparam logic [1:0] st_wait  = 2'd2;

  hbus_req_t req_in, req_out;
  hbus_rsp_t rsp_in, rsp_out;
  logic      req_empty, rsp_empty;
  logic      req_pop, rsp_pop, rsp_push;
  logic [1:0] seq;
  logic      pend_we; // outstanding request is a write

  assign req_in = '{we: req.wrq, adr: req.adr, dat: req.tx_dat, mask: req.tx_mask};

  hbus_cdc_fifo #(.payload_t(hbus_req_t)) u_req_fifo (
    .wr_clk_i  (wb_clk),
    .wr_rst_i  (wb_rst),
    .wr_en_i   (req.rrq | req.wrq),
    .wr_data_i (req_in),
    .full_o    (),
    .rd_clk_i  (hbus_clk),
    .rd_rst_i  (hbus_rst),
    .rd_en_i   (req_pop),
    .rd_data_o (req_out),
    .empty_o   (req_empty)
  );

  hbus_cdc_fifo #(.payload_t(hbus_rsp_t)) u_rsp_fifo (
    .wr_clk_i  (hbus_clk),
    .wr_rst_i  (hbus_rst),
    .wr_en_i   (rsp_push),
    .wr_data_i (rsp_in),
    .full_o    (),
    .rd_clk_i  (wb_clk),
    .rd_rst_i  (wb_rst),
    .rd_en_i   (rsp_pop),
    .rd_data_o (rsp_out),
    .empty_o   (rsp_empty)
  );

  // hbus side sequencer
  assign req_pop  = (seq == st_idle) & ~req_empty & ~hbus_busy; // busy stalls issue
  assign rsp_push = (seq == st_wait) & (pend_we ? hbus_ready : hbus_valid);
  assign rsp_in   = '{we: pend_we, dat: hbus_dat_i};

  always_ff @(posedge hbus_clk) begin
    if (hbus_rst) begin
      seq      <= st_idle;
      hbus_rrq <= 1'b0;
      hbus_wrq <= 1'b0;
      pend_we  <= 1'b0;
    end else begin
      hbus_rrq <= 1'b0;
      hbus_wrq <= 1'b0;
      case (seq)
        st_idle: begin
          if (req_pop) begin
            hbus_wrq <= req_out.we;
            hbus_rrq <= ~req_out.we;
            pend_we  <= req_out.we;
            seq      <= st_issue;
          end
        end
        st_issue: seq <= st_wait; // strobe high this cycle
        st_wait: begin
          if (rsp_push) seq <= st_idle;
        end
        default: seq <= st_idle;
      endcase
    end
  end

  // held until the next pop
  always_ff @(posedge hbus_clk) begin
    if (req_pop) begin
      hbus_adr_o  <= req_out.adr;
      hbus_dat_o  <= req_out.dat;
      hbus_mask_o <= req_out.mask;
    end
  end

  // wb side, response back to completion pulses
  assign rsp_pop = ~rsp_empty;

  always_ff @(posedge wb_clk) begin
    if (wb_rst) begin
      req.tx_ready <= 1'b0;
      req.rx_valid <= 1'b0;
    end else begin
      req.tx_ready <= rsp_pop & rsp_out.we;
      req.rx_valid <= rsp_pop & ~rsp_out.we;
    end
  end

  always_ff @(posedge wb_clk) begin
    if (rsp_pop) begin
      req.rx_dat <= rsp_out.dat;
    end
  end

endmodule

`default_nettype wire

//--- sim.f
+incdir+common
common/hbus_pkg.sv
common/hbus_req_if.sv
hyperbus_fifo/hbus_cdc_fifo.sv
hyperbus_fifo/hyperbus_fifo.sv
hw/hyperbus_wishbone.sv
hw/hyperbus_bridge_top.sv
sim/tb_hbus_mem_model.sv
sim/tb_hyperbus_bridge.sv

//--- sim/tb_hbus_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "hbus_macros.svh"

module tb_hbus_mem_model (
  input  wire                         hbus_clk,
  input  wire                         hbus_rst,
  input  wire [`HBUS_ADDR_WIDTH-1:0]  hbus_adr_i,
  input  wire [`HBUS_DATA_WIDTH-1:0]  hbus_dat_i,
  input  hbus_pkg::hbus_mask_t        hbus_mask_i,
  input  wire                         hbus_rrq_i,
  input  wire                         hbus_wrq_i,
  output logic [`HBUS_DATA_WIDTH-1:0] hbus_dat_o,
  output logic                        hbus_ready_o,
  output logic                        hbus_valid_o,
  output logic                        hbus_busy_o
);

  logic [`HBUS_DATA_WIDTH-1:0] mem [64];
  logic [15:0] lfsr;
  logic [2:0]  delay;   // cycles left before the answer
  logic        pending;
  logic        pend_we;
  int          idx;

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]}; // x^16+x^14+x^13+x^11+1
  endfunction

  // one lfsr step per bit taken
  function automatic logic [1:0] take_bits(input int n);
    logic [1:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[0], lfsr[0]};
    end
    return v;
  endfunction

  initial begin
    hbus_dat_o   = '0;
    hbus_ready_o = 1'b0;
    hbus_valid_o = 1'b0;
    hbus_busy_o  = 1'b0;
    for (int i = 0; i < 64; i++) begin
      mem[i] = i * 32'h0101_0101 ^ 32'hA5A5_A5A5;
    end
  end

  always @(posedge hbus_clk) begin
    if (hbus_rst) begin
      lfsr = 16'd48006;
      pending      <= 1'b0;
      hbus_ready_o <= 1'b0;
      hbus_valid_o <= 1'b0;
      hbus_busy_o  <= 1'b0;
    end else begin
      hbus_ready_o <= 1'b0;
      hbus_valid_o <= 1'b0;
      hbus_busy_o  <= (take_bits(1) == 2'd1);
      idx = hbus_adr_i[7:2];
      if (hbus_rrq_i || hbus_wrq_i) begin
        pending <= 1'b1;
        pend_we <= hbus_wrq_i;
        delay   <= take_bits(2) + 3'd1; // 1 to 4 cycles
      end else if (pending && delay > 3'd1) begin
        delay <= delay - 3'd1;
      end else if (pending) begin
        pending <= 1'b0;
        if (pend_we) begin
          for (int b = 0; b < 4; b++) begin
            if (!hbus_mask_i[b])
              mem[idx][8*b +: 8] <= hbus_dat_i[8*b +: 8]; // masked lanes kept
          end
          hbus_ready_o <= 1'b1;
        end else begin
          hbus_dat_o   <= mem[idx];
          hbus_valid_o <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- sim/tb_hyperbus_bridge.sv
`timescale 1ns/1ps
`default_nettype none

`include "hbus_macros.svh"

module tb_hyperbus_bridge;
  import hbus_pkg::*;

  typedef struct packed {
    logic                        we;
    logic [`HBUS_ADDR_WIDTH-1:0] adr;
    logic [`WB_DATA_WIDTH-1:0]   dat;
    logic [`WB_DATA_WIDTH/8-1:0] sel;
    logic [`WB_DATA_WIDTH-1:0]   exp;  // read value from the shadow
  } entry_t;

  logic wb_clk = 1'b0;
  logic hbus_clk = 1'b0;
  logic wb_rst = 1'b1;
  logic hbus_rst = 1'b1;
  logic [`HBUS_ADDR_WIDTH-1:0] wb_adr_i = '0;
  logic [`WB_DATA_WIDTH-1:0]   wb_dat_i = '0;
  logic [`WB_DATA_WIDTH/8-1:0] wb_sel_i = '0;
  logic wb_we_i = 1'b0;
  logic wb_cyc_i = 1'b0;
  logic wb_stb_i = 1'b0;
  logic [`WB_DATA_WIDTH-1:0]   wb_dat_o;
  logic wb_ack_o;
  logic [`HBUS_ADDR_WIDTH-1:0] hbus_adr_o;
  logic [`HBUS_DATA_WIDTH-1:0] hbus_dat_o, hbus_dat_i;
  hbus_mask_t hbus_mask_o;
  logic hbus_rrq, hbus_wrq, hbus_ready, hbus_valid, hbus_busy;

  logic [`WB_DATA_WIDTH-1:0] shadow [64];
  entry_t stim_q[$];
  entry_t cur;
  int errors = 0;
  int ack_count = 0;
  int req_count = 0;
  logic ack_prev = 1'b0;

  always #10 wb_clk = ~wb_clk;
  always #7 hbus_clk = ~hbus_clk;

  hyperbus_bridge_top DUT (.*);

  tb_hbus_mem_model u_mem (
    .hbus_clk     (hbus_clk),
    .hbus_rst     (hbus_rst),
    .hbus_adr_i   (hbus_adr_o),
    .hbus_dat_i   (hbus_dat_o),
    .hbus_mask_i  (hbus_mask_o),
    .hbus_rrq_i   (hbus_rrq),
    .hbus_wrq_i   (hbus_wrq),
    .hbus_dat_o   (hbus_dat_i),
    .hbus_ready_o (hbus_ready),
    .hbus_valid_o (hbus_valid),
    .hbus_busy_o  (hbus_busy)
  );

  task automatic check_data(input string what, input logic [`WB_DATA_WIDTH-1:0] got, exp);
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_adr(input logic [`HBUS_ADDR_WIDTH-1:0] got, exp);
    if (got !== exp) begin
      errors++;
      $display("error at %0t: hbus_adr_o got %h expected %h", $time, got, exp);
    end
  endtask

  task automatic check_mask(input hbus_mask_t got, exp);
    if (got !== exp) begin
      errors++;
      $display("error at %0t: hbus_mask_o got %b expected %b", $time, got, exp);
    end
  endtask

  task automatic check_count(input string what, input int got, exp);
    if (got != exp) begin
      errors++;
      $display("error at %0t: %s count %0d expected %0d", $time, what, got, exp);
    end
  endtask

  // shadow merge by sel, reads take the current shadow word
  task automatic add_entry(input logic we, input logic [31:0] adr, dat, input logic [3:0] sel);
    entry_t e;
    int idx;
    idx = adr[7:2];
    if (we) begin
      for (int b = 0; b < 4; b++) begin
        if (sel[b])
          shadow[idx][8*b +: 8] = dat[8*b +: 8];
      end
    end
    e = '{we, adr, dat, sel, shadow[idx]};
    stim_q.push_back(e);
  endtask

  always @(posedge hbus_clk) begin
    if (!hbus_rst && (hbus_rrq === 1'b1 || hbus_wrq === 1'b1)) begin
      req_count++;
      check_adr(hbus_adr_o, {cur.adr[`HBUS_ADDR_WIDTH-1:2], 2'b00});
      if (hbus_wrq !== cur.we) begin
        errors++;
        $display("error at %0t: hbus request type differs from the Wishbone cycle", $time);
      end
      if (hbus_wrq) begin
        check_mask(hbus_mask_o, ~cur.sel); // mask is inverted sel
        check_data("hbus_dat_o", hbus_dat_o, cur.dat);
      end
    end
  end

  always @(posedge wb_clk) begin
    if (!wb_rst) begin
      if (wb_ack_o === 1'b1) begin
        ack_count++;
        if (ack_prev) begin
          errors++;
          $display("error at %0t: wb_ack_o high for two cycles", $time);
        end
      end
      ack_prev = (wb_ack_o === 1'b1);
    end
  end

  initial begin
    repeat (4) @(posedge hbus_clk);
    hbus_rst <= 1'b0;
  end

  initial begin
    @(negedge wb_rst);
    repeat (stim_q.size() * 200) @(posedge wb_clk);
    $display("timeout: bridge did not finish within %0d wb_clk cycles", stim_q.size() * 200);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    for (int i = 0; i < 64; i++) begin
      shadow[i] = i * 32'h0101_0101 ^ 32'hA5A5_A5A5;
    end
    add_entry(1, 32'h0000_0010, 32'hDEAD_BEEF, 4'b1111);
    add_entry(0, 32'h0000_0010, '0, 4'b1111);
    add_entry(1, 32'h0000_0020, 32'h1122_3344, 4'b0001);
    add_entry(0, 32'h0000_0020, '0, 4'b1111);
    add_entry(1, 32'h0000_0020, 32'h5566_7788, 4'b0110);
    add_entry(0, 32'h0000_0020, '0, 4'b1111);
    add_entry(1, 32'h0000_0020, 32'h99AA_BBCC, 4'b1000);
    add_entry(0, 32'h0000_0020, '0, 4'b1111);
    add_entry(1, 32'h0000_0033, 32'hCAFE_F00D, 4'b1111); // unaligned
    add_entry(0, 32'h0000_0031, '0, 4'b1111);
    add_entry(0, 32'h0000_0084, '0, 4'b1111);             // never written
    add_entry(0, 32'h0000_00FE, '0, 4'b1111);
    add_entry(1, 32'h0000_0106, 32'h0BAD_CAFE, 4'b0011); // aliases word 1
    add_entry(0, 32'h0000_0004, '0, 4'b1111);

    // reset phase, strobes and ack must stay low
    for (int n = 0; n < 6; n++) begin
      @(posedge wb_clk);
      if (n > 0 && (wb_ack_o !== 1'b0 || hbus_rrq !== 1'b0 || hbus_wrq !== 1'b0)) begin
        errors++;
        $display("error at %0t: ack or request strobe not low around reset", $time);
      end
      if (n == 3)
        wb_rst <= 1'b0;
    end

    for (int i = 0; i < stim_q.size(); i++) begin
      cur = stim_q[i];
      wb_adr_i <= cur.adr;
      wb_dat_i <= cur.dat;
      wb_sel_i <= cur.sel;
      wb_we_i  <= cur.we;
      wb_cyc_i <= 1'b1;
      wb_stb_i <= 1'b1;
      do @(posedge wb_clk); while (wb_ack_o !== 1'b1);
      wb_cyc_i <= 1'b0;
      wb_stb_i <= 1'b0;
      if (!cur.we)
        check_data("wb_dat_o", wb_dat_o, cur.exp);
      @(posedge wb_clk);
    end

    repeat (10) @(posedge wb_clk);
    check_count("wb_ack_o", ack_count, stim_q.size());
    check_count("hbus request", req_count, stim_q.size());
    $display("errors %0d, acks %0d, hbus requests %0d, entries %0d",
             errors, ack_count, req_count, stim_q.size());
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
